// File: hw/isaPkg.sv
// isaPkg: word and register widths, opcodes, function codes, extend-mode and busB-select encodings
package isaPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount     = 32;
    localparam int immWidth     = 16;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] opSpecial = 6'h00;   // R-type, see function code
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opCop0    = 6'h10;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // function codes for opSpecial, instr[5:0]
    localparam logic [5:0] fnSll  = 6'h00;      // only the all-zero NOP form is accepted
    localparam logic [5:0] fnMfhi = 6'h10;
    localparam logic [5:0] fnMflo = 6'h12;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    // COP0 sub-op in the rs field
    localparam logic [4:0] cop0Mf = 5'b00000;

    // immediate extension
    typedef enum logic [1:0] {
        extZero  = 2'd0,
        extSign  = 2'd1,
        extUpper = 2'd2     // LUI, imm16 in the high half
    } extMode;

    // source of the second operand
    typedef enum logic [1:0] {
        selReg = 2'd0,
        selHi  = 2'd1,
        selLo  = 2'd2,
        selCp0 = 2'd3
    } busBSel;

endpackage

// File: hw/pipePkg.sv
// pipePkg: ALU op and branch type enums, IF/ID and ID/EX payload structs, NOP values
package pipePkg;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4,
        aluLui = 3'd5   // pass the extended immediate
    } aluOp;

    typedef enum logic [1:0] {
        brNone = 2'd0,
        brBeq  = 2'd1,
        brJump = 2'd2
    } branchType;

    typedef struct packed {
        logic                             valid;
        logic [isaPkg::dataWidth-1:0]     instr;
        logic [isaPkg::dataWidth-1:0]     pc;
    } ifIdPayload;

    typedef struct packed {
        logic                             valid;
        logic [isaPkg::dataWidth-1:0]     pc;
        logic [isaPkg::dataWidth-1:0]     imm32;
        logic [isaPkg::dataWidth-1:0]     busA;
        logic [isaPkg::dataWidth-1:0]     busB;
        logic [isaPkg::regAddrWidth-1:0]  rs;
        logic [isaPkg::regAddrWidth-1:0]  rt;
        logic [isaPkg::regAddrWidth-1:0]  rd;
        aluOp                             aluOp;
        logic                             aluSrcImm;
        logic                             regWrite;
        logic                             dstIsRt;
        logic                             memRead;
        logic                             memWrite;
        logic                             linkWrite;
        branchType                        branchType;
        logic                             exceptRI;
    } idExPayload;

    // bubble values, every valid/write/mem flag low
    localparam ifIdPayload ifIdNop = '0;
    localparam idExPayload idExNop = '0;

endpackage

// File: hw/stageReg.sv
// stageReg: pipeline register with flush and write enable, type-parameterized payload
`timescale 1ns/10ps

module stageReg #(
    parameter type payloadT = pipePkg::ifIdPayload
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    flush,
    input  logic    write,
    input  payloadT nopValue,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= nopValue;
        end else if (flush) begin   // flush wins over write
            q <= nopValue;
        end else if (write) begin
            q <= d;
        end
    end

    // a flushed stage must come out as a bubble
    flushGivesBubble: assert property (
        @(posedge clk) disable iff (!arstN)
        flush |=> !q.valid
    ) else $error("stage not invalid after flush");

endmodule

// File: hw/regFile.sv
// regFile: 32x32 register file, two async read ports, one sync write port, r0 hardwired zero
`timescale 1ns/10ps

module regFile (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             writeEnable,
    input  logic [isaPkg::regAddrWidth-1:0]  writeAddr,
    input  logic [isaPkg::dataWidth-1:0]     writeData,
    input  logic [isaPkg::regAddrWidth-1:0]  readAddrA,
    input  logic [isaPkg::regAddrWidth-1:0]  readAddrB,
    output logic [isaPkg::dataWidth-1:0]     readDataA,
    output logic [isaPkg::dataWidth-1:0]     readDataB
);

    logic [isaPkg::dataWidth-1:0] regs [isaPkg::regCount];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < isaPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin   // r0 writes dropped
            regs[writeAddr] <= writeData;
        end
    end

    // same-cycle WB bypass lives in operandSelect
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

    r0StaysZero: assert property (
        @(posedge clk) disable iff (!arstN)
        regs[0] == '0
    ) else $error("register 0 changed");

endmodule

// File: hw/instrDecoder.sv
// instrDecoder: opcode/function decode into control fields and the reserved-instruction flag
`timescale 1ns/10ps

module instrDecoder (
    input  logic [isaPkg::dataWidth-1:0] instr,
    output pipePkg::aluOp                aluOp,
    output logic                         aluSrcImm,
    output isaPkg::extMode               extSel,
    output isaPkg::busBSel               busBSel,
    output logic                         regWrite,
    output logic                         dstIsRt,
    output logic                         memRead,
    output logic                         memWrite,
    output logic                         linkWrite,
    output pipePkg::branchType           branchType,
    output logic                         isImmJump,
    output logic [1:0]                   rsrtRead,   // [1] rs used, [0] rt used
    output logic                         exceptRI
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rsField;

    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign rsField = instr[25:21];

    always_comb begin
        // defaults describe a bubble
        aluOp      = pipePkg::aluAdd;
        aluSrcImm  = 1'b0;
        extSel     = isaPkg::extSign;
        busBSel    = isaPkg::selReg;
        regWrite   = 1'b0;
        dstIsRt    = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        linkWrite  = 1'b0;
        branchType = pipePkg::brNone;
        isImmJump  = 1'b0;
        rsrtRead   = 2'b00;
        exceptRI   = 1'b0;

        unique case (opcode)
            isaPkg::opSpecial: begin
                unique case (funct)
                    isaPkg::fnAddu: begin
                        aluOp = pipePkg::aluAdd; regWrite = 1'b1; rsrtRead = 2'b11;
                    end
                    isaPkg::fnSubu: begin
                        aluOp = pipePkg::aluSub; regWrite = 1'b1; rsrtRead = 2'b11;
                    end
                    isaPkg::fnAnd: begin
                        aluOp = pipePkg::aluAnd; regWrite = 1'b1; rsrtRead = 2'b11;
                    end
                    isaPkg::fnOr: begin
                        aluOp = pipePkg::aluOr; regWrite = 1'b1; rsrtRead = 2'b11;
                    end
                    isaPkg::fnSlt: begin
                        aluOp = pipePkg::aluSlt; regWrite = 1'b1; rsrtRead = 2'b11;
                    end
                    isaPkg::fnMfhi: begin
                        aluOp = pipePkg::aluOr; busBSel = isaPkg::selHi; regWrite = 1'b1;
                    end
                    isaPkg::fnMflo: begin
                        aluOp = pipePkg::aluOr; busBSel = isaPkg::selLo; regWrite = 1'b1;
                    end
                    isaPkg::fnSll: exceptRI = (instr != '0);   // only SLL r0 = NOP
                    default:       exceptRI = 1'b1;
                endcase
            end
            isaPkg::opAddiu: begin
                aluSrcImm = 1'b1; regWrite = 1'b1; dstIsRt = 1'b1; rsrtRead = 2'b10;
            end
            isaPkg::opOri: begin
                aluOp     = pipePkg::aluOr;
                extSel    = isaPkg::extZero;
                aluSrcImm = 1'b1; regWrite = 1'b1; dstIsRt = 1'b1; rsrtRead = 2'b10;
            end
            isaPkg::opLui: begin
                aluOp  = pipePkg::aluLui;
                extSel = isaPkg::extUpper;
                aluSrcImm = 1'b1; regWrite = 1'b1; dstIsRt = 1'b1;
            end
            isaPkg::opLw: begin
                aluSrcImm = 1'b1; regWrite = 1'b1; dstIsRt = 1'b1;
                memRead   = 1'b1; rsrtRead = 2'b10;
            end
            isaPkg::opSw: begin
                aluSrcImm = 1'b1; memWrite = 1'b1; rsrtRead = 2'b11;   // rt is store data
            end
            isaPkg::opBeq: begin
                aluOp = pipePkg::aluSub; branchType = pipePkg::brBeq; rsrtRead = 2'b11;
            end
            isaPkg::opJ: begin
                branchType = pipePkg::brJump; isImmJump = 1'b1;
            end
            isaPkg::opJal: begin
                branchType = pipePkg::brJump; isImmJump = 1'b1;
                regWrite   = 1'b1; linkWrite = 1'b1;    // $31 <- return address
            end
            isaPkg::opCop0: begin
                if (rsField == isaPkg::cop0Mf) begin    // MFC0 rt, rd
                    aluOp = pipePkg::aluOr; busBSel = isaPkg::selCp0;
                    regWrite = 1'b1; dstIsRt = 1'b1;
                end else begin
                    exceptRI = 1'b1;
                end
            end
            default: exceptRI = 1'b1;
        endcase
    end

    memExclusive: assert final (!(memRead && memWrite))
        else $error("load and store decoded together");

endmodule

// File: hw/operandSelect.sv
// operandSelect: immediate extension, WB forwarding for rs/rt/CP0, busB four-way select
`timescale 1ns/10ps

module operandSelect (
    input  logic [isaPkg::immWidth-1:0]      imm16,
    input  isaPkg::extMode                   extSel,
    input  isaPkg::busBSel                   busBSel,
    input  logic [isaPkg::regAddrWidth-1:0]  rs,
    input  logic [isaPkg::regAddrWidth-1:0]  rt,
    input  logic [isaPkg::regAddrWidth-1:0]  rd,
    input  logic [isaPkg::dataWidth-1:0]     rfDataA,
    input  logic [isaPkg::dataWidth-1:0]     rfDataB,
    input  logic [isaPkg::dataWidth-1:0]     wbResult,
    input  logic [isaPkg::regAddrWidth-1:0]  wbDst,
    input  logic                             wbRegWrite,
    input  logic                             wbCp0Write,
    input  logic [isaPkg::dataWidth-1:0]     hiData,
    input  logic [isaPkg::dataWidth-1:0]     loData,
    input  logic [isaPkg::dataWidth-1:0]     cp0Data,
    output logic [isaPkg::dataWidth-1:0]     imm32,
    output logic [isaPkg::dataWidth-1:0]     busA,
    output logic [isaPkg::dataWidth-1:0]     busB
);

    logic                          fwdA;
    logic                          fwdB;
    logic                          fwdCp0;
    logic [isaPkg::dataWidth-1:0]  regB;     // rt value after forwarding
    logic [isaPkg::dataWidth-1:0]  cp0Val;

    always_comb begin
        case (extSel)
            isaPkg::extZero:  imm32 = {16'h0000, imm16};
            isaPkg::extUpper: imm32 = {imm16, 16'h0000};
            default:          imm32 = {{16{imm16[15]}}, imm16};
        endcase
    end

    // WB -> ID bypass, r0 never forwarded
    assign fwdA   = wbRegWrite && (wbDst == rs) && (wbDst != '0);
    assign fwdB   = wbRegWrite && (wbDst == rt) && (wbDst != '0);
    assign fwdCp0 = wbCp0Write && (wbDst == rd);

    assign busA   = fwdA   ? wbResult : rfDataA;
    assign regB   = fwdB   ? wbResult : rfDataB;
    assign cp0Val = fwdCp0 ? wbResult : cp0Data;

    always_comb begin
        case (busBSel)
            isaPkg::selHi:  busB = hiData;
            isaPkg::selLo:  busB = loData;
            isaPkg::selCp0: busB = cp0Val;
            default:        busB = regB;
        endcase
    end

endmodule

// File: hw/decodeStage.sv
// decodeStage: IF/ID register, register file, decoder, operand select and ID/EX register
`timescale 1ns/10ps

module decodeStage (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             idWrite,
    input  logic                             idFlush,
    input  logic                             exWrite,
    input  logic                             exFlush,
    input  logic [isaPkg::dataWidth-1:0]     ifInstr,
    input  logic [isaPkg::dataWidth-1:0]     ifPc,
    input  logic                             ifValid,
    input  logic [isaPkg::dataWidth-1:0]     wbResult,
    input  logic [isaPkg::regAddrWidth-1:0]  wbDst,
    input  logic                             wbRegWrite,
    input  logic                             wbCp0Write,
    input  logic [isaPkg::dataWidth-1:0]     hiData,
    input  logic [isaPkg::dataWidth-1:0]     loData,
    input  logic [isaPkg::dataWidth-1:0]     cp0Data,
    output logic [isaPkg::regAddrWidth-1:0]  idRs,          // to hazard unit
    output logic [isaPkg::regAddrWidth-1:0]  idRt,
    output logic [1:0]                       idRsrtRead,
    output logic                             idIsImmJump,
    output logic                             exValid,
    output logic [isaPkg::dataWidth-1:0]     exPc,
    output logic [isaPkg::dataWidth-1:0]     exImm32,
    output logic [isaPkg::dataWidth-1:0]     exBusA,
    output logic [isaPkg::dataWidth-1:0]     exBusB,
    output logic [isaPkg::regAddrWidth-1:0]  exRs,
    output logic [isaPkg::regAddrWidth-1:0]  exRt,
    output logic [isaPkg::regAddrWidth-1:0]  exRd,
    output pipePkg::aluOp                    exAluOp,
    output logic                             exAluSrcImm,
    output logic                             exRegWrite,
    output logic                             exDstIsRt,
    output logic                             exMemRead,
    output logic                             exMemWrite,
    output logic                             exLinkWrite,
    output pipePkg::branchType               exBranchType,
    output logic                             exExceptRI
);

    pipePkg::ifIdPayload            ifIdD, ifIdQ;
    pipePkg::idExPayload            idExD, idExQ;
    logic [isaPkg::regAddrWidth-1:0] idRd;
    logic [isaPkg::dataWidth-1:0]   rfDataA, rfDataB;
    logic [isaPkg::dataWidth-1:0]   idImm32, idBusA, idBusB;
    pipePkg::aluOp                  idAluOp;
    pipePkg::branchType             idBranchType;
    isaPkg::extMode                 idExtSel;
    isaPkg::busBSel                 idBusBSel;
    logic idAluSrcImm, idRegWrite, idDstIsRt, idMemRead, idMemWrite, idLinkWrite, idExceptRI;

    assign ifIdD = '{valid: ifValid, instr: ifInstr, pc: ifPc};

    stageReg #(.payloadT(pipePkg::ifIdPayload)) ifIdReg (
        .clk(clk), .arstN(arstN), .flush(idFlush), .write(idWrite),
        .nopValue(pipePkg::ifIdNop), .d(ifIdD), .q(ifIdQ)
    );

    assign idRs = ifIdQ.instr[25:21];
    assign idRt = ifIdQ.instr[20:16];
    assign idRd = ifIdQ.instr[15:11];

    regFile regFile_i (
        .clk(clk), .arstN(arstN),
        .writeEnable(wbRegWrite), .writeAddr(wbDst), .writeData(wbResult),
        .readAddrA(idRs), .readAddrB(idRt), .readDataA(rfDataA), .readDataB(rfDataB)
    );

    instrDecoder instrDecoder_i (
        .instr(ifIdQ.instr), .aluOp(idAluOp), .aluSrcImm(idAluSrcImm), .extSel(idExtSel),
        .busBSel(idBusBSel), .regWrite(idRegWrite), .dstIsRt(idDstIsRt),
        .memRead(idMemRead), .memWrite(idMemWrite), .linkWrite(idLinkWrite),
        .branchType(idBranchType), .isImmJump(idIsImmJump), .rsrtRead(idRsrtRead),
        .exceptRI(idExceptRI)
    );

    operandSelect operandSelect_i (
        .imm16(ifIdQ.instr[15:0]), .extSel(idExtSel), .busBSel(idBusBSel),
        .rs(idRs), .rt(idRt), .rd(idRd), .rfDataA(rfDataA), .rfDataB(rfDataB),
        .wbResult(wbResult), .wbDst(wbDst), .wbRegWrite(wbRegWrite), .wbCp0Write(wbCp0Write),
        .hiData(hiData), .loData(loData), .cp0Data(cp0Data),
        .imm32(idImm32), .busA(idBusA), .busB(idBusB)
    );

    assign idExD = '{
        valid: ifIdQ.valid, pc: ifIdQ.pc, imm32: idImm32, busA: idBusA, busB: idBusB,
        rs: idRs, rt: idRt, rd: idRd, aluOp: idAluOp, aluSrcImm: idAluSrcImm,
        regWrite: idRegWrite, dstIsRt: idDstIsRt, memRead: idMemRead, memWrite: idMemWrite,
        linkWrite: idLinkWrite, branchType: idBranchType, exceptRI: idExceptRI
    };

    stageReg #(.payloadT(pipePkg::idExPayload)) idExReg (
        .clk(clk), .arstN(arstN), .flush(exFlush), .write(exWrite),
        .nopValue(pipePkg::idExNop), .d(idExD), .q(idExQ)
    );

    assign exValid      = idExQ.valid;
    assign exPc         = idExQ.pc;
    assign exImm32      = idExQ.imm32;
    assign exBusA       = idExQ.busA;
    assign exBusB       = idExQ.busB;
    assign exRs         = idExQ.rs;
    assign exRt         = idExQ.rt;
    assign exRd         = idExQ.rd;
    assign exAluOp      = idExQ.aluOp;
    assign exAluSrcImm  = idExQ.aluSrcImm;
    assign exRegWrite   = idExQ.regWrite;
    assign exDstIsRt    = idExQ.dstIsRt;
    assign exMemRead    = idExQ.memRead;
    assign exMemWrite   = idExQ.memWrite;
    assign exLinkWrite  = idExQ.linkWrite;
    assign exBranchType = idExQ.branchType;
    assign exExceptRI   = idExQ.exceptRI;

endmodule

// File: verification/clockGen.sv
// clockGen: free-running testbench clock and active-low reset pulse
`timescale 1ns/10ps

module clockGen #(
    parameter int periodNs    = 8,
    parameter int resetCycles = 10
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2.0) clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;   // released away from the rising edge
    end

endmodule

// File: verification/decodeStageTb.sv
// decodeStageTb: table-driven testbench for the decode stage, register model, watchdog
`timescale 1ns/10ps

module decodeStageTb;

    localparam int          clkPeriod   = 8;
    localparam int          resetCycles = 10;
    localparam int          maxRows     = 32;
    localparam logic [31:0] pcBase      = 32'h0040_0000;
    localparam logic [1:0]  mRun        = 2'd0;
    localparam logic [1:0]  mHold       = 2'd1;   // idWrite and exWrite low together
    localparam logic [1:0]  mIdFl       = 2'd2;
    localparam logic [1:0]  mExFl       = 2'd3;

    logic               clk, arstN;
    logic               idWrite, idFlush, exWrite, exFlush, ifValid, wbRegWrite, wbCp0Write;
    logic [31:0]        ifInstr, ifPc, wbResult, hiData, loData, cp0Data;
    logic [4:0]         wbDst, idRs, idRt, exRs, exRt, exRd;
    logic [1:0]         idRsrtRead;
    logic               idIsImmJump, exValid, exAluSrcImm, exRegWrite, exDstIsRt;
    logic               exMemRead, exMemWrite, exLinkWrite, exExceptRI;
    logic [31:0]        exPc, exImm32, exBusA, exBusB;
    pipePkg::aluOp      exAluOp;
    pipePkg::branchType exBranchType;

    typedef struct packed {
        logic [31:0] instr;
        logic [1:0]  mode;
        logic [1:0]  wb;      // {regWrite, cp0Write}
        logic [4:0]  wbDst;
        logic [31:0] wbRes;
        logic [14:0] ctl;     // aluOp _ srcImm regWr dstRt memRd memWr link _ branch _ RI _ rsrt _ jmp
        logic [31:0] imm;     // only checked with srcImm set
        logic [1:0]  bSrc;    // 0 reg, 1 hi, 2 lo, 3 cp0
    } tableRow;

    tableRow     rows [0:maxRows-1];
    int          rowCount;
    bit          tableBuilt;
    logic [31:0] model [0:31];   // expected register file contents
    int unsigned lcgState = 3609;
    int          errCount, checkCount;

    clockGen #(.periodNs(clkPeriod), .resetCycles(resetCycles)) clockGen_i (
        .clk(clk), .arstN(arstN)
    );

    decodeStage decodeStage_i (
        .clk(clk), .arstN(arstN), .idWrite(idWrite), .idFlush(idFlush),
        .exWrite(exWrite), .exFlush(exFlush), .ifInstr(ifInstr), .ifPc(ifPc),
        .ifValid(ifValid), .wbResult(wbResult), .wbDst(wbDst), .wbRegWrite(wbRegWrite),
        .wbCp0Write(wbCp0Write), .hiData(hiData), .loData(loData), .cp0Data(cp0Data),
        .idRs(idRs), .idRt(idRt), .idRsrtRead(idRsrtRead), .idIsImmJump(idIsImmJump),
        .exValid(exValid), .exPc(exPc), .exImm32(exImm32), .exBusA(exBusA),
        .exBusB(exBusB), .exRs(exRs), .exRt(exRt), .exRd(exRd), .exAluOp(exAluOp),
        .exAluSrcImm(exAluSrcImm), .exRegWrite(exRegWrite), .exDstIsRt(exDstIsRt),
        .exMemRead(exMemRead), .exMemWrite(exMemWrite), .exLinkWrite(exLinkWrite),
        .exBranchType(exBranchType), .exExceptRI(exExceptRI)
    );

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] fn, input int rs, rt, rd);
        return {isaPkg::opSpecial, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input int rs, rt,
                                          input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    // register value seen by decode, WB bypass first
    function automatic logic [31:0] fwdOrModel(input logic [4:0] idx, input tableRow r);
        if (r.wb[1] && r.wbDst == idx && idx != 5'd0)
            return r.wbRes;
        return model[idx];
    endfunction

    function automatic logic [155:0] exState();
        return {exValid, exPc, exImm32, exBusA, exBusB, exRs, exRt, exRd, exAluOp,
                exAluSrcImm, exRegWrite, exDstIsRt, exMemRead, exMemWrite, exLinkWrite,
                exBranchType, exExceptRI};
    endfunction

    task automatic addRow(input logic [31:0] instr, input logic [1:0] mode, wb,
                          input logic [4:0] wbDst, input logic [31:0] wbRes,
                          input logic [14:0] ctl, input logic [31:0] imm,
                          input logic [1:0] bSrc);
        rows[rowCount] = {instr, mode, wb, wbDst, wbRes, ctl, imm, bSrc};
        rowCount++;
    endtask

    task automatic buildTable();
        rowCount = 0;
        // instr, mode, wb, wbDst, wbRes, ctl, imm, bSrc
        addRow(rType(isaPkg::fnAddu, 1, 2, 3), mRun, 2'b10, 1, 32'hcafe0001,
               15'b000_010000_00_0_11_0, 0, 0);
        addRow(rType(isaPkg::fnSubu, 4, 5, 6), mRun, 2'b10, 5, 32'hbeef0005,
               15'b001_010000_00_0_11_0, 0, 0);
        addRow(rType(isaPkg::fnAnd, 0, 31, 7), mRun, 0, 0, 0,
               15'b010_010000_00_0_11_0, 0, 0);   // r0 read
        addRow(rType(isaPkg::fnOr, 0, 5, 8), mRun, 2'b10, 0, 32'hdeadbeef,
               15'b011_010000_00_0_11_0, 0, 0);
        addRow(rType(isaPkg::fnSlt, 1, 9, 10), mRun, 0, 0, 0,
               15'b100_010000_00_0_11_0, 0, 0);
        addRow(iType(isaPkg::opAddiu, 3, 4, 16'h8001), mRun, 0, 0, 0,
               15'b000_111000_00_0_10_0, 32'hffff8001, 0);
        addRow(iType(isaPkg::opOri, 2, 5, 16'h8001), mRun, 0, 0, 0,
               15'b011_111000_00_0_10_0, 32'h00008001, 0);
        addRow(iType(isaPkg::opLui, 0, 6, 16'h1234), mRun, 0, 0, 0,
               15'b101_111000_00_0_00_0, 32'h12340000, 0);
        addRow(iType(isaPkg::opLw, 29, 8, 16'hfffc), mRun, 0, 0, 0,
               15'b000_111100_00_0_10_0, 32'hfffffffc, 0);
        addRow(iType(isaPkg::opSw, 29, 9, 16'h0010), mRun, 0, 0, 0,
               15'b000_100010_00_0_11_0, 32'h00000010, 0);
        addRow(iType(isaPkg::opBeq, 1, 2, 16'h0003), mRun, 0, 0, 0,
               15'b001_000000_01_0_11_0, 0, 0);
        addRow(iType(isaPkg::opJ, 0, 0, 16'h0100), mRun, 0, 0, 0,
               15'b000_000000_10_0_00_1, 0, 0);
        addRow(iType(isaPkg::opJal, 0, 0, 16'h0200), mRun, 0, 0, 0,
               15'b000_010001_10_0_00_1, 0, 0);
        addRow(rType(isaPkg::fnMfhi, 0, 0, 11), mRun, 0, 0, 0,
               15'b011_010000_00_0_00_0, 0, 1);
        addRow(rType(isaPkg::fnMflo, 0, 0, 12), mRun, 0, 0, 0,
               15'b011_010000_00_0_00_0, 0, 2);
        // MFC0 rt 13, rd 12
        addRow(iType(isaPkg::opCop0, 0, 13, 16'h6000), mRun, 0, 0, 0,
               15'b011_011000_00_0_00_0, 0, 3);
        addRow(iType(isaPkg::opCop0, 0, 13, 16'h6000), mRun, 2'b01, 12, 32'h00c0ffee,
               15'b011_011000_00_0_00_0, 0, 3);
        addRow(iType(6'h3f, 1, 2, 16'h0000), mRun, 0, 0, 0,
               15'b000_000000_00_1_00_0, 0, 0);
        addRow(rType(isaPkg::fnSubu, 4, 5, 6), mHold, 0, 0, 0, 0, 0, 0);
        addRow(rType(isaPkg::fnOr, 1, 2, 3), mIdFl, 0, 0, 0, 0, 0, 0);
        addRow(rType(isaPkg::fnAddu, 14, 15, 16), mRun, 0, 0, 0,
               15'b000_010000_00_0_11_0, 0, 0);
        addRow(rType(isaPkg::fnAnd, 1, 2, 3), mExFl, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic checkValue(input string what, input logic [31:0] got, exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("Fail %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkRow(input int n);
        tableRow     r;
        string       tag;
        logic        live;
        logic [31:0] ins;
        logic [31:0] expB;
        r    = rows[n];
        tag  = $sformatf("row %0d", n);
        live = (r.mode == mRun);
        ins  = live ? r.instr : 32'h0;   // flushed rows come out as all-zero bubbles
        case (r.bSrc)
            2'd1:    expB = hiData;
            2'd2:    expB = loData;
            2'd3:    expB = (r.wb[0] && r.wbDst == ins[15:11]) ? r.wbRes : cp0Data;
            default: expB = fwdOrModel(ins[20:16], r);
        endcase
        checkValue({tag, " valid"}, exValid, live);
        checkValue({tag, " pc"}, exPc, live ? pcBase + 4 * n : 32'h0);
        checkValue({tag, " busA"}, exBusA, fwdOrModel(ins[25:21], r));
        checkValue({tag, " busB"}, exBusB, expB);
        checkValue({tag, " rs/rt/rd"}, {exRs, exRt, exRd}, ins[25:11]);
        checkValue({tag, " control"}, {exAluOp, exAluSrcImm, exRegWrite, exDstIsRt,
                   exMemRead, exMemWrite, exLinkWrite, exBranchType, exExceptRI},
                   r.ctl[14:3]);
        if (r.ctl[11])
            checkValue({tag, " imm32"}, exImm32, r.imm);
    endtask

    initial begin
        tableRow      r;
        logic [155:0] held;
        {idWrite, idFlush, exWrite, exFlush, ifValid, wbRegWrite, wbCp0Write} = '0;
        {ifInstr, ifPc, wbResult, hiData, loData, cp0Data, wbDst} = '0;
        for (int i = 0; i < 32; i++)
            model[i] = '0;
        buildTable();
        tableBuilt = 1'b1;
        wait (arstN === 1'b1);
        @(negedge clk);
        checkValue("control flags after reset", {exValid, exRegWrite, exMemRead,
                   exMemWrite, exLinkWrite, exExceptRI}, 0);
        // fill every register through WB, r0 included
        for (int i = 0; i < isaPkg::regCount; i++) begin
            wbRegWrite = 1'b1;
            wbDst      = i[4:0];
            wbResult   = nextRand();
            if (i != 0)
                model[i] = wbResult;
            @(negedge clk);
        end
        wbRegWrite = 1'b0;
        for (int n = 0; n < rowCount; n++) begin
            r       = rows[n];
            held    = exState();
            ifInstr = r.instr;             // row enters IF/ID
            ifPc    = pcBase + 4 * n;
            ifValid = 1'b1;
            idWrite = (r.mode != mHold);
            idFlush = (r.mode == mIdFl);
            exWrite = (r.mode != mHold);
            exFlush = 1'b0;
            {wbRegWrite, wbCp0Write} = 2'b00;
            @(negedge clk);
            if (r.mode == mRun || r.mode == mExFl)
                checkValue($sformatf("row %0d idRs/idRt", n), {idRs, idRt}, r.instr[25:16]);
            if (r.mode == mRun)
                checkValue($sformatf("row %0d hazard flags", n),
                           {idRsrtRead, idIsImmJump}, r.ctl[2:0]);
            ifInstr  = 32'h0;              // bubble follows the row, ID/EX takes the row
            ifPc     = 32'h0;
            ifValid  = 1'b0;
            idFlush  = 1'b0;
            exFlush  = (r.mode == mExFl);
            {wbRegWrite, wbCp0Write} = r.wb;
            wbDst    = r.wbDst;
            wbResult = r.wbRes;
            hiData   = nextRand();
            loData   = nextRand();
            cp0Data  = nextRand();
            @(negedge clk);
            if (r.mode == mHold) begin
                checkCount++;
                if (exState() !== held) begin
                    errCount++;
                    $display("Fail %0t ns: row %0d ex outputs changed while stalled",
                             $time, n);
                end
            end else begin
                checkRow(n);
            end
            if (r.wb[1] && r.wbDst != 5'd0)
                model[r.wbDst] = r.wbRes;
        end
        $display("Checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // each table row and preload write gets four clock periods
    initial begin
        wait (tableBuilt);
        #((rowCount + isaPkg::regCount) * clkPeriod * 4 + resetCycles * clkPeriod);
        $display("Watchdog expired before the stimulus table finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: decodeStage.f
hw/isaPkg.sv
hw/pipePkg.sv
hw/stageReg.sv
hw/regFile.sv
hw/instrDecoder.sv
hw/operandSelect.sv
hw/decodeStage.sv
verification/clockGen.sv
verification/decodeStageTb.sv
